// File: hw/tcdm_pkg.sv
// Widths, vector types and the AMO opcode encoding of the TCDM bank
// Request, response and SRAM command structs shared by all blocks
package tcdm_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------

  // Cores that can address the bank
  localparam int unsigned NumCores        = 16;
  // Bank depth the address width is derived from
  localparam int unsigned DefaultNumWords = 1024;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned AddrWidth   = $clog2(DefaultNumWords);
  localparam int unsigned CoreIdWidth = (NumCores > 1) ? $clog2(NumCores) : 1;
  localparam int unsigned TagWidth    = 4;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  // Word address inside the bank
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [BeWidth-1:0]     be_t;
  typedef logic [CoreIdWidth-1:0] core_id_t;
  // Transaction tag, echoed back unchanged
  typedef logic [TagWidth-1:0]    tag_t;

  // Atomic opcodes as carried on the interconnect
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9,
    AmoLr   = 4'hA,
    AmoSc   = 4'hB
  } amo_op_e;

  // --------------------------------------------------
  // Bus structs
  // --------------------------------------------------

  // Metadata returned with every response
  typedef struct packed {
    core_id_t core_id;
    tag_t     tag;
  } tcdm_meta_t;

  typedef struct packed {
    addr_t      addr;
    amo_op_e    amo;
    logic       write;
    data_t      wdata;
    be_t        be;
    tcdm_meta_t meta;
  } tcdm_req_t;

  typedef struct packed {
    data_t      rdata;
    tcdm_meta_t meta;
  } tcdm_resp_t;

  // Command towards the single-port bank
  typedef struct packed {
    logic  req;
    logic  write;
    addr_t addr;
    data_t wdata;
    be_t   be;
  } sram_req_t;

endpackage

// File: hw/amo_alu.sv
// Read-modify-write arithmetic for the atomic opcodes
// One 33-bit adder serves add and the max/min compares
`timescale 1ns/1ps

module amo_alu (
  input  tcdm_pkg::amo_op_e op_i,
  // Old memory value
  input  tcdm_pkg::data_t   operand_a_i,
  // Operand from the request
  input  tcdm_pkg::data_t   operand_b_i,
  output tcdm_pkg::data_t   result_o
);

  logic        is_signed;
  logic        is_cmp;
  logic [32:0] adder_a;
  logic [32:0] adder_b;
  logic [32:0] adder_sum;
  // Memory value is below the request operand
  logic        a_less;

  // --------------------------------------------------
  // Shared adder
  // --------------------------------------------------

  always_comb begin
    is_signed = op_i inside {tcdm_pkg::AmoMax, tcdm_pkg::AmoMin};
    is_cmp    = op_i inside {tcdm_pkg::AmoMax, tcdm_pkg::AmoMaxu,
                             tcdm_pkg::AmoMin, tcdm_pkg::AmoMinu};
    // Sign extend for signed compares, zero extend otherwise
    adder_a   = {is_signed & operand_a_i[31], operand_a_i};
    adder_b   = {is_signed & operand_b_i[31], operand_b_i};
    // Compare as a - b, carry in supplies the +1
    if (is_cmp) begin
      adder_b = ~adder_b;
    end
  end

  assign adder_sum = adder_a + adder_b + {32'd0, is_cmp};
  // Bit 32 is the sign of the difference in both cases
  assign a_less    = adder_sum[32];

  // --------------------------------------------------
  // Result select
  // --------------------------------------------------

  always_comb begin
    unique case (op_i)
      tcdm_pkg::AmoSwap: result_o = operand_b_i;
      tcdm_pkg::AmoAdd:  result_o = adder_sum[31:0];
      tcdm_pkg::AmoAnd:  result_o = operand_a_i & operand_b_i;
      tcdm_pkg::AmoOr:   result_o = operand_a_i | operand_b_i;
      tcdm_pkg::AmoXor:  result_o = operand_a_i ^ operand_b_i;
      tcdm_pkg::AmoMax,
      tcdm_pkg::AmoMaxu: result_o = a_less ? operand_b_i : operand_a_i;
      tcdm_pkg::AmoMin,
      tcdm_pkg::AmoMinu: result_o = a_less ? operand_a_i : operand_b_i;
      // Non-arithmetic opcodes leave the word as it was
      default:           result_o = operand_a_i;
    endcase
  end

endmodule

// File: hw/lrsc_monitor.sv
// Single LR reservation for the bank
// Decides SC success and keeps the SC result for the response cycle
`timescale 1ns/1ps

module lrsc_monitor #(
  parameter bit LrScEnable = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request accepted this cycle
  input  logic               accept_i,
  input  tcdm_pkg::addr_t    addr_i,
  input  tcdm_pkg::amo_op_e  amo_i,
  input  logic               write_i,
  input  tcdm_pkg::core_id_t core_i,
  // SC in this cycle may write
  output logic               sc_success_o,
  // An SC was accepted in the previous cycle
  output logic               sc_pending_o,
  output logic               sc_fail_q_o
);

  typedef struct packed {
    logic               valid;
    tcdm_pkg::addr_t    addr;
    tcdm_pkg::core_id_t core;
  } resv_t;

  resv_t resv_d;
  resv_t resv_q;
  logic  modifies;
  logic  is_sc;

  // Plain stores and arithmetic atomics change memory
  assign modifies = (write_i && amo_i == tcdm_pkg::AmoNone) ||
                    !(amo_i inside {tcdm_pkg::AmoNone, tcdm_pkg::AmoLr, tcdm_pkg::AmoSc});
  assign is_sc    = amo_i == tcdm_pkg::AmoSc;

  always_comb begin
    resv_d       = resv_q;
    sc_success_o = 1'b0;
    if (accept_i) begin
      // New reservation only if free or already held by this core
      if (LrScEnable && amo_i == tcdm_pkg::AmoLr &&
          (!resv_q.valid || resv_q.core == core_i)) begin
        resv_d.valid = 1'b1;
        resv_d.addr  = addr_i;
        resv_d.core  = core_i;
      end
      // Another core writing the reserved word breaks the pair
      if (modifies && resv_q.core != core_i && resv_q.addr == addr_i) begin
        resv_d.valid = 1'b0;
      end
      // SC from the holder always consumes the reservation
      if (is_sc && resv_q.valid && resv_q.core == core_i) begin
        resv_d.valid = 1'b0;
        sc_success_o = LrScEnable && (resv_q.addr == addr_i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_q       <= '0;
      sc_pending_o <= 1'b0;
      sc_fail_q_o  <= 1'b0;
    end else begin
      resv_q       <= resv_d;
      sc_pending_o <= accept_i && is_sc;
      sc_fail_q_o  <= !sc_success_o;
    end
  end

endmodule

// File: hw/resp_buffer.sv
// Response buffer of the bank
// Two-entry metadata queue paired with a fall-through read data register
`timescale 1ns/1ps

module resp_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Metadata arrives at request acceptance
  input  logic                 meta_push_i,
  input  tcdm_pkg::tcdm_meta_t meta_i,
  // Read data arrives one cycle later
  input  logic                 data_push_i,
  input  tcdm_pkg::data_t      data_i,
  // Room for another response
  output logic                 ready_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  output tcdm_pkg::tcdm_resp_t resp_o
);

  tcdm_pkg::tcdm_meta_t meta_q [2];
  logic                 wr_ptr_q;
  logic                 rd_ptr_q;
  logic [1:0]           meta_cnt_q;
  tcdm_pkg::data_t      data_q;
  logic                 data_valid_q;
  logic                 data_avail;
  logic                 pop;

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------

  // Data from the bank may pass straight through
  assign data_avail   = data_valid_q || data_push_i;
  assign valid_o      = (meta_cnt_q != 2'd0) && data_avail;
  assign pop          = valid_o && ready_i;
  assign ready_o      = meta_cnt_q != 2'd2;
  assign resp_o.meta  = meta_q[rd_ptr_q];
  assign resp_o.rdata = data_valid_q ? data_q : data_i;

  // --------------------------------------------------
  // Metadata queue
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      meta_cnt_q <= 2'd0;
    end else begin
      if (meta_push_i) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      // Count only moves when push and pop differ
      if (meta_push_i && !pop) begin
        meta_cnt_q <= meta_cnt_q + 2'd1;
      end else if (!meta_push_i && pop) begin
        meta_cnt_q <= meta_cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_q[wr_ptr_q] <= meta_i;
    end
  end

  // --------------------------------------------------
  // Read data register
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_q <= 1'b0;
    end else if (pop) begin
      // Held word leaves, a word pushed now stays behind it
      data_valid_q <= data_valid_q && data_push_i;
    end else if (data_push_i) begin
      data_valid_q <= 1'b1;
    end
  end

  // Capture unless the new word fell through in this cycle
  always_ff @(posedge clk_i) begin
    if (data_push_i && (data_valid_q || !pop)) begin
      data_q <= data_i;
    end
  end

endmodule

// File: hw/sram_bank.sv
// Single-port word memory with byte enables
// Read data is registered and valid one cycle after the request
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NumWords = tcdm_pkg::DefaultNumWords
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  tcdm_pkg::sram_req_t req_i,
  output tcdm_pkg::data_t     rdata_o
);

  tcdm_pkg::data_t mem_q [NumWords];

  // Byte-masked write, one lane per enable bit
  always_ff @(posedge clk_i) begin
    if (req_i.req && req_i.write) begin
      for (int unsigned b = 0; b < tcdm_pkg::BeWidth; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Output register keeps the last read word during writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i.req && !req_i.write) begin
      rdata_o <= mem_q[req_i.addr];
    end
  end

endmodule

// File: hw/tcdm_adapter.sv
// Request stage in front of one SRAM bank
// Accepts requests, runs AMOs as read-modify-write and handles LR/SC
// Responses return in order through the response buffer
`timescale 1ns/1ps

module tcdm_adapter #(
  // Extra register stage before AMO write-back
  parameter bit RegisterAmo = 1'b0,
  parameter bit LrScEnable  = 1'b1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Interconnect side
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  tcdm_pkg::tcdm_req_t  in_req_i,
  output logic                 in_valid_o,
  input  logic                 in_ready_i,
  output tcdm_pkg::tcdm_resp_t in_resp_o,
  // Bank side
  output tcdm_pkg::sram_req_t  sram_req_o,
  input  tcdm_pkg::data_t      sram_rdata_i
);

  typedef enum logic [1:0] {
    Idle,
    DoAmo,
    WriteBackAmo
  } state_e;

  state_e            state_d;
  state_e            state_q;
  logic              accept;
  logic              is_store;
  logic              is_amo;
  logic              load_amo;
  logic              wb_claim;
  logic              buf_ready;
  logic              data_push_q;
  logic              sc_success;
  logic              sc_pending;
  logic              sc_fail_q;
  tcdm_pkg::amo_op_e amo_op_q;
  tcdm_pkg::addr_t   addr_q;
  tcdm_pkg::data_t   operand_b_q;
  tcdm_pkg::data_t   amo_result;
  tcdm_pkg::data_t   amo_result_q;
  tcdm_pkg::data_t   wb_data;
  tcdm_pkg::data_t   resp_rdata;

  // --------------------------------------------------
  // Acceptance
  // --------------------------------------------------

  // Stall while an AMO owns the bank or a response waits
  assign in_ready_o = (state_q == Idle) && buf_ready && !(in_valid_o && !in_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign is_store   = in_req_i.write && (in_req_i.amo == tcdm_pkg::AmoNone);
  assign is_amo     = !(in_req_i.amo inside {tcdm_pkg::AmoNone, tcdm_pkg::AmoLr,
                                             tcdm_pkg::AmoSc});
  assign load_amo   = accept && is_amo;

  // Write-back cycle of the AMO
  assign wb_claim = (state_q == DoAmo && !RegisterAmo) || (state_q == WriteBackAmo);
  assign wb_data  = RegisterAmo ? amo_result_q : amo_result;

  always_comb begin
    // Accepted requests go straight to the bank
    sram_req_o.req   = accept;
    sram_req_o.write = is_store || sc_success;
    sram_req_o.addr  = in_req_i.addr;
    sram_req_o.wdata = in_req_i.wdata;
    // SC stores the whole word
    sram_req_o.be    = sc_success ? '1 : in_req_i.be;
    if (wb_claim) begin
      sram_req_o.req   = 1'b1;
      sram_req_o.write = 1'b1;
      sram_req_o.addr  = addr_q;
      sram_req_o.wdata = wb_data;
      sram_req_o.be    = '1;
    end
  end

  // --------------------------------------------------
  // AMO FSM
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:         state_d = load_amo ? DoAmo : Idle;
      // Old value is on the bank output here
      DoAmo:        state_d = RegisterAmo ? WriteBackAmo : Idle;
      WriteBackAmo: state_d = Idle;
      default:      state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      data_push_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // Every non-store gets its read data one cycle later
      data_push_q <= accept && !is_store;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      amo_op_q    <= in_req_i.amo;
      addr_q      <= in_req_i.addr;
      operand_b_q <= in_req_i.wdata;
    end
    if (state_q == DoAmo) begin
      amo_result_q <= amo_result;
    end
  end

  amo_alu i_amo_alu (
    .op_i        (amo_op_q),
    .operand_a_i (sram_rdata_i),
    .operand_b_i (operand_b_q),
    .result_o    (amo_result)
  );

  // --------------------------------------------------
  // LR/SC and response
  // --------------------------------------------------

  lrsc_monitor #(
    .LrScEnable (LrScEnable)
  ) i_lrsc_monitor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .accept_i     (accept),
    .addr_i       (in_req_i.addr),
    .amo_i        (in_req_i.amo),
    .write_i      (in_req_i.write),
    .core_i       (in_req_i.meta.core_id),
    .sc_success_o (sc_success),
    .sc_pending_o (sc_pending),
    .sc_fail_q_o  (sc_fail_q)
  );

  // SC answers 0 on success and 1 on failure
  assign resp_rdata = sc_pending ? tcdm_pkg::data_t'(sc_fail_q) : sram_rdata_i;

  resp_buffer i_resp_buffer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .meta_push_i (accept && !is_store),
    .meta_i      (in_req_i.meta),
    .data_push_i (data_push_q),
    .data_i      (resp_rdata),
    .ready_o     (buf_ready),
    .valid_o     (in_valid_o),
    .ready_i     (in_ready_i),
    .resp_o      (in_resp_o)
  );

endmodule

// File: hw/tcdm_bank_top.sv
// One TCDM memory bank
// Request adapter in front of a single-port SRAM
`timescale 1ns/1ps

module tcdm_bank_top #(
  parameter bit          RegisterAmo = 1'b0,
  parameter bit          LrScEnable  = 1'b1,
  parameter int unsigned NumWords    = tcdm_pkg::DefaultNumWords
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Request channel
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  tcdm_pkg::tcdm_req_t  req_i,
  // Response channel
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output tcdm_pkg::tcdm_resp_t resp_o
);

  tcdm_pkg::sram_req_t sram_req;
  tcdm_pkg::data_t     sram_rdata;

  tcdm_adapter #(
    .RegisterAmo (RegisterAmo),
    .LrScEnable  (LrScEnable)
  ) i_tcdm_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (req_valid_i),
    .in_ready_o   (req_ready_o),
    .in_req_i     (req_i),
    .in_valid_o   (resp_valid_o),
    .in_ready_i   (resp_ready_i),
    .in_resp_o    (resp_o),
    .sram_req_o   (sram_req),
    .sram_rdata_i (sram_rdata)
  );

  sram_bank #(
    .NumWords (NumWords)
  ) i_sram_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

endmodule

// File: bench/tb_clock_gen.sv
// Clock and reset source of the testbench
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned Period      = 100,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  // Reset leaves on a falling edge, away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: bench/tb_tcdm_bank.sv
// Testbench of the TCDM bank
// Reference memory and reservation model, expected response queue
// Tests for reset, loads and stores, atomics, LR/SC and back-pressure
`timescale 1ns/1ps

module tb_tcdm_bank;

  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned FillWords   = 32;
  localparam int unsigned NumStores   = 40;
  localparam int unsigned NumLoads    = 40;
  localparam int unsigned AmoCases    = 4;
  localparam int unsigned NumLrSc     = 12;
  localparam int unsigned NumMixed    = 80;
  // Requests of all tests together, sizes the watchdog
  localparam int unsigned TotalReqs = FillWords + NumStores + NumLoads + 9 * AmoCases * 3 +
                                      NumLrSc + NumMixed;

  logic                 clk;
  logic                 rst_n;
  logic                 req_valid;
  logic                 req_ready;
  tcdm_pkg::tcdm_req_t  req;
  logic                 resp_valid;
  logic                 resp_ready;
  tcdm_pkg::tcdm_resp_t resp;

  // Model state
  tcdm_pkg::data_t      ref_mem [tcdm_pkg::DefaultNumWords];
  logic                 resv_valid;
  tcdm_pkg::addr_t      resv_addr;
  tcdm_pkg::core_id_t   resv_core;
  tcdm_pkg::tcdm_resp_t exp_q [$];
  tcdm_pkg::tag_t       next_tag;
  logic                 back_pressure;
  int unsigned          checks;
  int unsigned          errors;
  int unsigned          test_base;

  tb_clock_gen #(
    .Period      (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) i_tb_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_bank_top #(
    .RegisterAmo (1'b0),
    .LrScEnable  (1'b1),
    .NumWords    (tcdm_pkg::DefaultNumWords)
  ) i_tcdm_bank_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_i        (req),
    .resp_valid_o (resp_valid),
    .resp_ready_i (resp_ready),
    .resp_o       (resp)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  function automatic tcdm_pkg::data_t merge_bytes(tcdm_pkg::data_t old_word,
                                                  tcdm_pkg::data_t new_word,
                                                  tcdm_pkg::be_t be);
    tcdm_pkg::data_t word;
    word = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // New memory value of an atomic, from the RISC-V A extension rules
  function automatic tcdm_pkg::data_t amo_expected(tcdm_pkg::amo_op_e op,
                                                   tcdm_pkg::data_t mem_val,
                                                   tcdm_pkg::data_t operand);
    case (op)
      tcdm_pkg::AmoSwap: return operand;
      tcdm_pkg::AmoAdd:  return mem_val + operand;
      tcdm_pkg::AmoAnd:  return mem_val & operand;
      tcdm_pkg::AmoOr:   return mem_val | operand;
      tcdm_pkg::AmoXor:  return mem_val ^ operand;
      tcdm_pkg::AmoMax:  return ($signed(mem_val) > $signed(operand)) ? mem_val : operand;
      tcdm_pkg::AmoMaxu: return (mem_val > operand) ? mem_val : operand;
      tcdm_pkg::AmoMin:  return ($signed(mem_val) < $signed(operand)) ? mem_val : operand;
      tcdm_pkg::AmoMinu: return (mem_val < operand) ? mem_val : operand;
      default:           return mem_val;
    endcase
  endfunction

  // Operands around the sign boundary split signed from unsigned compares
  function automatic tcdm_pkg::data_t pick_operand();
    case ($urandom % 6)
      0:       return 32'h7fff_ffff;
      1:       return 32'h8000_0000;
      2:       return 32'h8000_0001;
      3:       return 32'hffff_ffff;
      4:       return 32'h0000_0001;
      default: return $urandom;
    endcase
  endfunction

  // A write by another core to the reserved word drops the reservation
  task automatic snoop_write(tcdm_pkg::tcdm_req_t r);
    if (resv_valid && resv_core != r.meta.core_id && resv_addr == r.addr) begin
      resv_valid = 1'b0;
    end
  endtask

  // Memory, reservation and expected response for one accepted request
  task automatic predict(tcdm_pkg::tcdm_req_t r);
    tcdm_pkg::tcdm_resp_t exp;
    logic                 holder;
    holder    = resv_valid && resv_core == r.meta.core_id;
    exp.meta  = r.meta;
    exp.rdata = ref_mem[r.addr];
    case (r.amo)
      tcdm_pkg::AmoNone: begin
        if (r.write) begin
          ref_mem[r.addr] = merge_bytes(ref_mem[r.addr], r.wdata, r.be);
          snoop_write(r);
        end else begin
          exp_q.push_back(exp);
        end
      end
      tcdm_pkg::AmoLr: begin
        if (!resv_valid || holder) begin
          resv_valid = 1'b1;
          resv_addr  = r.addr;
          resv_core  = r.meta.core_id;
        end
        exp_q.push_back(exp);
      end
      tcdm_pkg::AmoSc: begin
        // 0 on success, 1 on failure
        exp.rdata = 32'd1;
        if (holder) begin
          resv_valid = 1'b0;
          if (resv_addr == r.addr) begin
            ref_mem[r.addr] = r.wdata;
            exp.rdata       = 32'd0;
          end
        end
        exp_q.push_back(exp);
      end
      default: begin
        ref_mem[r.addr] = amo_expected(r.amo, ref_mem[r.addr], r.wdata);
        snoop_write(r);
        exp_q.push_back(exp);
      end
    endcase
  endtask

  // --------------------------------------------------
  // Cycle handling and checks
  // --------------------------------------------------

  task automatic compare_resp();
    tcdm_pkg::tcdm_resp_t exp;
    if (exp_q.size() == 0) begin
      $display("error at %0t: response with tag %0h arrived while none was outstanding",
               $time, resp.meta.tag);
      errors++;
      return;
    end
    exp = exp_q.pop_front();
    checks++;
    assert (resp.meta === exp.meta) else begin
      $display("mismatch at %0t: resp_o.meta expected %h got %h", $time, exp.meta, resp.meta);
      errors++;
    end
    assert (resp.rdata === exp.rdata) else begin
      $display("mismatch at %0t: resp_o.rdata expected %h got %h",
               $time, exp.rdata, resp.rdata);
      errors++;
    end
  endtask

  // Inputs were driven at the falling edge, outputs settle before sampling
  task automatic end_cycle(output logic fired);
    #1;
    fired = req_valid && req_ready;
    if (resp_valid && !resp_ready) begin
      assert (!req_ready) else begin
        $display("error at %0t: req_ready_o is high while a response waits", $time);
        errors++;
      end
    end
    if (resp_valid && resp_ready) begin
      compare_resp();
    end
    @(negedge clk);
    resp_ready = back_pressure ? (($urandom % 3) != 0) : 1'b1;
  endtask

  task automatic issue_req(tcdm_pkg::amo_op_e op, logic write, tcdm_pkg::addr_t addr,
                           tcdm_pkg::data_t wdata, tcdm_pkg::be_t be,
                           tcdm_pkg::core_id_t core);
    logic fired;
    req.addr         = addr;
    req.amo          = op;
    req.write        = write;
    req.wdata        = wdata;
    req.be           = be;
    req.meta.core_id = core;
    req.meta.tag     = next_tag;
    req_valid        = 1'b1;
    next_tag++;
    // Hold valid and payload until the bank takes the request
    do begin
      end_cycle(fired);
    end while (!fired);
    predict(req);
    req_valid = 1'b0;
  endtask

  // Idle cycles at the end catch duplicated responses
  task automatic drain_responses();
    logic fired;
    while (exp_q.size() != 0) begin
      end_cycle(fired);
    end
    repeat (3) end_cycle(fired);
  endtask

  task automatic report_test(string name);
    $display("test %s done: %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  initial begin
    tcdm_pkg::addr_t    addr;
    tcdm_pkg::core_id_t core;
    int unsigned        kind;
    void'($urandom(42429));
    req_valid     = 1'b0;
    req           = '0;
    resp_ready    = 1'b1;
    back_pressure = 1'b0;
    resv_valid    = 1'b0;
    resv_addr     = '0;
    resv_core     = '0;
    next_tag      = '0;
    checks        = 0;
    errors        = 0;
    test_base     = 0;

    // Reset state
    @(posedge rst_n);
    @(negedge clk);
    #1;
    assert (resp_valid === 1'b0) else begin
      $display("mismatch at %0t: resp_valid_o expected 0 got %b", $time, resp_valid);
      errors++;
    end
    assert (req_ready === 1'b1) else begin
      $display("mismatch at %0t: req_ready_o expected 1 got %b", $time, req_ready);
      errors++;
    end
    @(negedge clk);
    report_test("reset");

    // Distinct word in each low address, then byte stores and loads
    for (int a = 0; a < FillWords; a++) begin
      issue_req(tcdm_pkg::AmoNone, 1'b1, tcdm_pkg::addr_t'(a), 32'h9e37_79b9 * (a + 1),
                4'hf, tcdm_pkg::core_id_t'(a));
    end
    for (int i = 0; i < NumStores; i++) begin
      issue_req(tcdm_pkg::AmoNone, 1'b1, tcdm_pkg::addr_t'($urandom % FillWords), $urandom,
                tcdm_pkg::be_t'($urandom), tcdm_pkg::core_id_t'($urandom));
    end
    for (int i = 0; i < NumLoads; i++) begin
      issue_req(tcdm_pkg::AmoNone, 1'b0, tcdm_pkg::addr_t'($urandom % FillWords), '0,
                4'hf, tcdm_pkg::core_id_t'($urandom));
    end
    drain_responses();
    report_test("loads_stores");

    // Each opcode: seed the word, run the atomic, read the result back
    for (int op = 1; op <= 9; op++) begin
      for (int c = 0; c < AmoCases; c++) begin
        addr = tcdm_pkg::addr_t'($urandom % FillWords);
        issue_req(tcdm_pkg::AmoNone, 1'b1, addr, pick_operand(), 4'hf, 0);
        issue_req(tcdm_pkg::amo_op_e'(op), 1'b0, addr, pick_operand(), 4'hf, 1);
        issue_req(tcdm_pkg::AmoNone, 1'b0, addr, '0, 4'hf, 2);
      end
    end
    drain_responses();
    report_test("atomics");

    // Successful pair
    issue_req(tcdm_pkg::AmoLr, 1'b0, 3, '0, 4'hf, 2);
    issue_req(tcdm_pkg::AmoSc, 1'b0, 3, 32'h1234_5678, 4'hf, 2);
    issue_req(tcdm_pkg::AmoNone, 1'b0, 3, '0, 4'hf, 2);
    // Store by another core breaks the reservation
    issue_req(tcdm_pkg::AmoLr, 1'b0, 5, '0, 4'hf, 2);
    issue_req(tcdm_pkg::AmoNone, 1'b1, 5, 32'hcafe_f00d, 4'hf, 7);
    issue_req(tcdm_pkg::AmoSc, 1'b0, 5, 32'hdead_beef, 4'hf, 2);
    issue_req(tcdm_pkg::AmoNone, 1'b0, 5, '0, 4'hf, 2);
    // No reservation
    issue_req(tcdm_pkg::AmoSc, 1'b0, 3, 32'h0bad_0bad, 4'hf, 2);
    issue_req(tcdm_pkg::AmoNone, 1'b0, 3, '0, 4'hf, 2);
    // Reservation on another address
    issue_req(tcdm_pkg::AmoLr, 1'b0, 3, '0, 4'hf, 2);
    issue_req(tcdm_pkg::AmoSc, 1'b0, 5, 32'h5555_aaaa, 4'hf, 2);
    issue_req(tcdm_pkg::AmoNone, 1'b0, 5, '0, 4'hf, 2);
    drain_responses();
    report_test("lr_sc");

    // Mixed traffic from a few cores while responses stall at random
    back_pressure = 1'b1;
    for (int i = 0; i < NumMixed; i++) begin
      addr = tcdm_pkg::addr_t'($urandom % FillWords);
      core = tcdm_pkg::core_id_t'($urandom % 4);
      kind = $urandom % 5;
      case (kind)
        0: issue_req(tcdm_pkg::AmoNone, 1'b1, addr, $urandom, tcdm_pkg::be_t'($urandom), core);
        1: issue_req(tcdm_pkg::AmoNone, 1'b0, addr, '0, 4'hf, core);
        2: issue_req(tcdm_pkg::amo_op_e'(1 + $urandom % 9), 1'b0, addr, pick_operand(),
                     4'hf, core);
        3: issue_req(tcdm_pkg::AmoLr, 1'b0, addr, '0, 4'hf, core);
        default: issue_req(tcdm_pkg::AmoSc, 1'b0, addr, $urandom, 4'hf, core);
      endcase
    end
    drain_responses();
    back_pressure = 1'b0;
    report_test("back_pressure");

    $display("responses checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Twenty cycles per request bounds the whole run
  initial begin
    #((ResetCycles + 20 * TotalReqs) * ClkPeriod);
    $display("timeout: run did not finish within %0d cycles", ResetCycles + 20 * TotalReqs);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: files.f
hw/tcdm_pkg.sv
hw/amo_alu.sv
hw/lrsc_monitor.sv
hw/resp_buffer.sv
hw/sram_bank.sv
hw/tcdm_adapter.sv
hw/tcdm_bank_top.sv
bench/tb_clock_gen.sv
bench/tb_tcdm_bank.sv
